// ==== filelist.f ====
verilog/geo_pkg.sv
verilog/geo_req_if.sv
verilog/geo_cmd_fifo.sv
verilog/geo_cmd_decoder.sv
verilog/geo_rect_engine.sv
verilog/geometry_xy_plotter.sv
tb/tb_geometry_xy_plotter.sv

// ==== Makefile ====
# Verilator build and run of the geometry plotter testbench

VERILATOR ?= verilator
TOP       ?= tb_geometry_xy_plotter
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_geometry_xy_plotter.sv ====
//********************************************************************
// directed testbench for the geometry plotter: clock, reset, watchdog
// config, rectangle, clipping and stall tests against a pixel model
//********************************************************************

`timescale 1ns/1ps

module tb_geometry_xy_plotter import geo_pkg::*; ();

  localparam int          FIFO_DEPTH  = 16;
  localparam int          FIFO_MARGIN = 4;
  localparam int          CLK_HALF    = 5;     // 10 ns period
  localparam int          WAIT_LIMIT  = 2000;  // cycles allowed per drain
  localparam int          RUN_CYCLES  = 20000; // five tests of a few hundred cycles, wide margin
  localparam logic [31:0] SEED        = 32'haaf63295;

  logic        clk = 1'b0;
  logic        reset;
  logic        fifo_cmd_ready;
  cmd_word_t   fifo_cmd_in;
  logic        draw_busy;
  logic        load_cmd;
  logic        draw_cmd_rdy;
  draw_cmd_t   draw_cmd;
  logic        fifo_cmd_busy;
  logic [35:0] got_q[$];             // commands taken by the pixel writer
  logic [35:0] exp_q[$];             // commands the model predicts
  int          errors = 0;
  int          checks = 0;
  coord_t      fx0, fy0, fx1, fy1;   // filled rectangle, redrawn under stall
  color_t      fcol;

  geometry_xy_plotter #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FIFO_MARGIN (FIFO_MARGIN)
  ) u_dut (
    .clk            (clk),
    .reset          (reset),
    .fifo_cmd_ready (fifo_cmd_ready),
    .fifo_cmd_in    (fifo_cmd_in),
    .draw_busy      (draw_busy),
    .load_cmd       (load_cmd),
    .draw_cmd_rdy   (draw_cmd_rdy),
    .draw_cmd       (draw_cmd),
    .fifo_cmd_busy  (fifo_cmd_busy)
  );

  always #CLK_HALF clk = ~clk;

  always @(posedge clk) begin
    if (draw_cmd_rdy) got_q.push_back(draw_cmd); // writer takes every ready cycle
  end

  initial begin
    #(RUN_CYCLES * 2 * CLK_HALF);
    $display("watchdog: run did not finish within %0d cycles", RUN_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  //******************************************************************
  // helpers and reference model
  //******************************************************************
  task automatic log_error(input string msg);
    errors++;
    $display("error at %0d ns: %s", $time, msg);
  endtask

  function automatic cmd_word_t coord_word(input logic is_y, input logic [1:0] idx,
                                           input coord_t v);
    return {1'b1, is_y, idx, v}; // 10ii sets x[i], 11ii sets y[i]
  endfunction

  task automatic push_word(input cmd_word_t w);
    fifo_cmd_ready = 1'b1;
    fifo_cmd_in    = w;
    @(posedge clk);
    #1;
    fifo_cmd_ready = 1'b0;
  endtask

  task automatic load_corners(input coord_t x0, input coord_t y0, input coord_t x1,
                              input coord_t y1);
    push_word(coord_word(1'b0, 2'd0, x0)); // first corner in pair 0
    push_word(coord_word(1'b1, 2'd0, y0));
    push_word(coord_word(1'b0, 2'd1, x1)); // second corner in pair 1
    push_word(coord_word(1'b1, 2'd1, y1));
  endtask

  // done when the FIFO is drained and the engine and output are idle
  task automatic wait_done(input logic jitter, input string what);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      done = load_cmd && u_dut.fifo_empty && !draw_cmd_rdy;
      #1;
      if (jitter && !done) draw_busy = ($urandom_range(0, 1) == 1); // random stall
      cycles++;
    end
    draw_busy = 1'b0;
    if (!done) begin
      errors++;
      $display("timeout: %s still busy after %0d cycles", what, WAIT_LIMIT);
    end
  endtask

  // rows from y0 toward y1, x from x0 toward x1 in each row
  task automatic rect_model(input coord_t x0, input coord_t y0, input coord_t x1,
                            input coord_t y1, input color_t col, input logic fill,
                            input coord_t lim_x, input coord_t lim_y);
    int   dx, dy, w, h, px, py;
    logic on_edge;
    dx = (x1 < x0) ? -1 : 1;
    dy = (y1 < y0) ? -1 : 1;
    w  = (x1 < x0) ? int'(x0) - int'(x1) : int'(x1) - int'(x0);
    h  = (y1 < y0) ? int'(y0) - int'(y1) : int'(y1) - int'(y0);
    for (int r = 0; r <= h; r++) begin
      for (int c = 0; c <= w; c++) begin
        px      = int'(x0) + c * dx;
        py      = int'(y0) + r * dy;
        on_edge = (r == 0) || (r == h) || (c == 0) || (c == w);
        if ((fill || on_edge) && px <= int'(lim_x) && py <= int'(lim_y))
          exp_q.push_back({DF_PXWRI, col, coord_t'(py), coord_t'(px)}); // clipped otherwise
      end
    end
  endtask

  task automatic compare_output(input string name);
    int n;
    n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
    checks++;
    if (got_q.size() != exp_q.size())
      log_error($sformatf("%s: %0d commands out, %0d expected", name, got_q.size(),
                          exp_q.size()));
    for (int i = 0; i < n; i++) begin
      checks++;
      if (got_q[i] !== exp_q[i])
        log_error($sformatf("%s: command %0d is %h, expected %h", name, i, got_q[i],
                            exp_q[i]));
    end
    got_q.delete();
    exp_q.delete();
  endtask

  //******************************************************************
  // tests
  //******************************************************************
  task automatic test_reset_state();
    checks++;
    if (draw_cmd_rdy !== 1'b0 || fifo_cmd_busy !== 1'b0 || load_cmd !== 1'b1)
      log_error($sformatf("after reset draw_cmd_rdy=%b fifo_cmd_busy=%b load_cmd=%b",
                          draw_cmd_rdy, fifo_cmd_busy, load_cmd));
  endtask

  task automatic test_config();
    coord_t px[4];
    coord_t py[4];
    color_t c;
    int     pair;
    for (int i = 0; i < 4; i++) begin
      px[i] = coord_t'($urandom);
      py[i] = coord_t'($urandom);
      push_word(coord_word(1'b0, 2'(i), px[i]));
      push_word(coord_word(1'b1, 2'(i), py[i]));
    end
    for (int i = 0; i < 4; i++) begin
      c = color_t'($urandom);
      push_word({6'b011111, 2'(i), c});                   // destination address
      exp_q.push_back({DF_DSTMADDR, c, py[i], px[i]});
      c = color_t'($urandom);
      push_word({6'b011110, 2'(i), c});                   // source address
      exp_q.push_back({DF_SRCMADDR, c, py[i], px[i]});
    end
    for (int k = 112; k <= 115; k++) begin
      c    = color_t'($urandom);
      pair = (k >= 114) ? 2 : 3;                          // 115 and 114 read pair 2
      push_word({8'(k), c});                              // odd codes are destination width
      exp_q.push_back({(k[0] ? DF_DSTRWDTH : DF_SRCRWDTH), c, py[pair], px[pair]});
    end
    for (int k = 90; k <= 91; k++) begin
      c = color_t'($urandom);
      push_word({8'(k), c});                              // mask color spread over y and x
      exp_q.push_back({(k[0] ? DF_RST_PXWRI_M : DF_RST_PXPASTE_M), c, {c, c[7:4]},
                       {c[3:0], c}});
    end
    for (int k = 116; k <= 119; k++) push_word({8'(k), color_t'($urandom)}); // reserved
    for (int k = 92; k <= 95; k++) push_word({8'(k), color_t'($urandom)});   // limits
    wait_done(1'b0, "config commands");
    compare_output("config commands");
  endtask

  task automatic test_filled_rect();
    fx0  = coord_t'($urandom_range(100, 150));
    fx1  = fx0 - coord_t'($urandom_range(1, 6));          // x steps down
    fy0  = coord_t'($urandom_range(200, 250));
    fy1  = fy0 + coord_t'($urandom_range(1, 5));          // y steps up
    fcol = color_t'($urandom);
    push_word(coord_word(1'b0, 2'd3, 12'hfff));
    push_word(coord_word(1'b1, 2'd3, 12'hfff));
    push_word({OP_SET_MAX3, 8'h00});                      // wide limit from pair 3
    load_corners(fx0, fy0, fx1, fy1);
    push_word({3'b000, 1'b1, 1'b0, SHAPE_RECT, fcol});
    wait_done(1'b0, "filled rectangle");
    rect_model(fx0, fy0, fx1, fy1, fcol, 1'b1, 12'hfff, 12'hfff);
    compare_output("filled rectangle");
  endtask

  task automatic test_outline_clip();
    coord_t ox0, oy0, ox1, oy1, lx, ly;
    color_t col;
    ox0 = coord_t'($urandom_range(300, 320));
    ox1 = ox0 + coord_t'($urandom_range(3, 8));
    oy0 = coord_t'($urandom_range(400, 420));
    oy1 = oy0 - coord_t'($urandom_range(3, 6));
    col = color_t'($urandom);
    load_corners(ox0, oy0, ox1, oy1);
    push_word({3'b000, 1'b0, 1'b0, SHAPE_RECT, col});     // outline only
    wait_done(1'b0, "outline rectangle");
    rect_model(ox0, oy0, ox1, oy1, col, 1'b0, 12'hfff, 12'hfff);
    compare_output("outline rectangle");
    ox0 = coord_t'($urandom_range(40, 50));
    ox1 = ox0 + 12'd8;
    oy0 = coord_t'($urandom_range(60, 70));
    oy1 = oy0 + 12'd6;
    lx  = ox0 + 12'd4;                                    // limit cuts through the rectangle
    ly  = oy0 + 12'd3;
    col = color_t'($urandom);
    push_word(coord_word(1'b0, 2'd1, lx));
    push_word(coord_word(1'b1, 2'd1, ly));
    push_word({OP_SET_MAX1, 8'h00});
    load_corners(ox0, oy0, ox1, oy1);
    push_word({3'b000, 1'b1, 1'b0, SHAPE_RECT, col});
    push_word({3'b000, 1'b1, 1'b0, 3'd5, col});           // unknown shape, no pixels
    wait_done(1'b0, "clipped rectangle");
    rect_model(ox0, oy0, ox1, oy1, col, 1'b1, lx, ly);
    compare_output("clipped rectangle");
  endtask

  task automatic test_backpressure();
    cmd_word_t words[$];
    words.push_back(coord_word(1'b0, 2'd3, 12'hfff));
    words.push_back(coord_word(1'b1, 2'd3, 12'hfff));
    words.push_back({OP_SET_MAX3, 8'h00});
    words.push_back(coord_word(1'b0, 2'd0, fx0));
    words.push_back(coord_word(1'b1, 2'd0, fy0));
    words.push_back(coord_word(1'b0, 2'd1, fx1));
    words.push_back(coord_word(1'b1, 2'd1, fy1));
    while (words.size() < FIFO_DEPTH - FIFO_MARGIN - 1)
      words.push_back(coord_word(1'b0, 2'd2, coord_t'($urandom))); // filler in pair 2
    words.push_back({3'b000, 1'b1, 1'b0, SHAPE_RECT, fcol});
    draw_busy = 1'b1;
    foreach (words[i]) push_word(words[i]);
    checks++;
    if (fifo_cmd_busy !== 1'b1)
      log_error("fifo_cmd_busy low with the FIFO filled to its margin");
    repeat (5) @(posedge clk);
    #1;
    checks++;
    if (got_q.size() != 0)
      log_error($sformatf("%0d commands out while draw_busy held", got_q.size()));
    wait_done(1'b1, "stalled rectangle");
    rect_model(fx0, fy0, fx1, fy1, fcol, 1'b1, 12'hfff, 12'hfff);
    compare_output("stalled rectangle");
  endtask

  initial begin
    void'($urandom(SEED));
    reset          = 1'b1;
    fifo_cmd_ready = 1'b0;
    fifo_cmd_in    = '0;
    draw_busy      = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    test_reset_state();
    test_config();
    test_filled_rect();
    test_outline_clip();
    test_backpressure();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== verilog/geometry_xy_plotter.sv ====
//********************************************************************
// geometry plotter top: command FIFO, decoder, rectangle engine
//********************************************************************

`timescale 1ns/1ps

module geometry_xy_plotter import geo_pkg::*; #(
  parameter int FIFO_DEPTH  = 16,
  parameter int FIFO_MARGIN = 4
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      fifo_cmd_ready, // command write strobe
  input  cmd_word_t fifo_cmd_in,
  input  logic      draw_busy,      // pixel writer stall
  output logic      load_cmd,       // plotter idle
  output logic      draw_cmd_rdy,
  output draw_cmd_t draw_cmd,
  output logic      fifo_cmd_busy   // FIFO nearly full
);

  logic      fifo_empty;
  logic      fifo_pop;
  cmd_word_t fifo_q;

  geo_req_if req_if ();

  geo_cmd_fifo #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FIFO_MARGIN (FIFO_MARGIN)
  ) u_fifo (
    .clk         (clk),
    .reset       (reset),
    .push        (fifo_cmd_ready),
    .data        (fifo_cmd_in),
    .pop         (fifo_pop),
    .q           (fifo_q),
    .empty       (fifo_empty),
    .almost_full (fifo_cmd_busy)
  );

  geo_cmd_decoder u_decoder (
    .clk       (clk),
    .reset     (reset),
    .draw_busy (draw_busy),
    .empty     (fifo_empty),
    .q         (fifo_q),
    .pop       (fifo_pop),
    .req       (req_if.decoder)
  );

  geo_rect_engine u_engine (
    .clk          (clk),
    .reset        (reset),
    .draw_busy    (draw_busy),
    .req          (req_if.engine),
    .draw_cmd     (draw_cmd),
    .draw_cmd_rdy (draw_cmd_rdy),
    .idle         (load_cmd)
  );

endmodule

// ==== verilog/geo_rect_engine.sv ====
//********************************************************************
// rectangle stepper, filled or outline, with clipping
// single draw command output register held by draw_busy
//********************************************************************

`timescale 1ns/1ps

module geo_rect_engine import geo_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      draw_busy,
  geo_req_if.engine req,
  output draw_cmd_t draw_cmd,
  output logic      draw_cmd_rdy,
  output logic      idle
);

  logic      run;      // rectangle walk in progress
  logic      out_full; // output register holds a command
  draw_cmd_t out_cmd;
  coord_t    cur_x;
  coord_t    cur_y;
  coord_t    x0;
  coord_t    y0;
  coord_t    x1;
  coord_t    y1;
  coord_t    lim_x;
  coord_t    lim_y;
  color_t    pen;
  logic      fill;
  logic      x_dec;    // step x downward
  logic      y_dec;    // step y downward
  logic      take;
  logic      row_edge; // first or last row
  logic      col_edge; // first or last column
  logic      visible;
  coord_t    next_x;
  coord_t    next_y;

  assign req.ready    = !draw_busy && !run;
  assign take         = req.valid && req.ready;
  assign row_edge     = (cur_y == y0) || (cur_y == y1);
  assign col_edge     = (cur_x == x0) || (cur_x == x1);
  assign visible      = (fill || row_edge || col_edge) && (cur_x <= lim_x) && (cur_y <= lim_y);
  assign next_x       = x_dec ? cur_x - COORD_W'(1) : cur_x + COORD_W'(1);
  assign next_y       = y_dec ? cur_y - COORD_W'(1) : cur_y + COORD_W'(1);
  assign draw_cmd     = out_cmd;
  assign draw_cmd_rdy = out_full && !draw_busy; // writer takes it every such cycle
  assign idle         = !run && !out_full && !req.valid;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      run      <= 1'b0;
      out_full <= 1'b0;
    end else if (!draw_busy) begin
      if (take) begin
        run      <= (req.kind == REQ_RECT);
        out_full <= (req.kind == REQ_CFG);
      end else if (run) begin
        out_full <= visible;                        // clipped pixels leave a gap
        if (cur_x == x1 && cur_y == y1) run <= 1'b0; // last corner reached
      end else begin
        out_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!draw_busy) begin
      if (take) begin
        out_cmd <= req.cmd;
        x0      <= req.x0;
        y0      <= req.y0;
        x1      <= req.x1;
        y1      <= req.y1;
        cur_x   <= req.x0;
        cur_y   <= req.y0;
        x_dec   <= (req.x1 < req.x0);
        y_dec   <= (req.y1 < req.y0);
        lim_x   <= req.max_x;
        lim_y   <= req.max_y;
        pen     <= req.color;
        fill    <= req.fill;
      end else if (run) begin
        out_cmd <= '{func: DF_PXWRI, color: pen, y: cur_y, x: cur_x};
        if (cur_x == x1) begin
          cur_x <= x0;                              // next row
          cur_y <= next_y;
        end else if (!fill && !row_edge) begin
          cur_x <= x1;                              // outline skips the interior
        end else begin
          cur_x <= next_x;
        end
      end
    end
  end

  a_out_hold : assert property (@(posedge clk) disable iff (reset)
    draw_busy && out_full |=> out_full && $stable(draw_cmd));

endmodule

// ==== verilog/geo_cmd_decoder.sv ====
//********************************************************************
// command decoder: x/y register pairs, screen limit
// builds config and rectangle requests for the engine
//********************************************************************

`timescale 1ns/1ps

module geo_cmd_decoder import geo_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       draw_busy,
  input  logic       empty,
  input  cmd_word_t  q,
  output logic       pop,
  geo_req_if.decoder req
);

  logic [7:0] opcode;     // cmd[15:8]
  color_t     arg8;       // cmd[7:0], color / mode byte
  coord_t     arg12;      // cmd[11:0], coordinate data
  coord_t     x [4];      // x0..x3
  coord_t     y [4];      // y0..y3
  coord_t     max_x;
  coord_t     max_y;
  logic       emit_cfg;   // word becomes a REQ_CFG
  logic       emit_rect;  // word starts a rectangle
  logic [1:0] width_pair; // pair read by the raster width codes
  draw_cmd_t  cfg_cmd;

  assign opcode     = q[15:8];
  assign arg8       = q[7:0];
  assign arg12      = q[11:0];
  assign width_pair = opcode[1] ? 2'd2 : 2'd3; // 115 and 114 use pair 2, 113 and 112 pair 3
  assign pop        = !empty && !draw_busy && !req.valid; // one word per cycle
  assign req.max_x  = max_x; // cannot change while a request waits
  assign req.max_y  = max_y;

  //******************************************************************
  // word decode
  //******************************************************************
  always_comb begin
    emit_cfg      = 1'b0;
    emit_rect     = 1'b0;
    cfg_cmd.func  = DF_NOP;
    cfg_cmd.color = arg8;                              // low byte always rides along
    cfg_cmd.y     = y[opcode[1:0]];
    cfg_cmd.x     = x[opcode[1:0]];
    casez (opcode)
      8'b011111?? : begin emit_cfg = 1'b1; cfg_cmd.func = DF_DSTMADDR; end
      8'b011110?? : begin emit_cfg = 1'b1; cfg_cmd.func = DF_SRCMADDR; end
      OP_DST_WIDTH2, OP_DST_WIDTH3 : begin
        emit_cfg     = 1'b1;
        cfg_cmd.func = DF_DSTRWDTH;
        cfg_cmd.y    = y[width_pair];
        cfg_cmd.x    = x[width_pair];
      end
      OP_SRC_WIDTH2, OP_SRC_WIDTH3 : begin
        emit_cfg     = 1'b1;
        cfg_cmd.func = DF_SRCRWDTH;
        cfg_cmd.y    = y[width_pair];
        cfg_cmd.x    = x[width_pair];
      end
      OP_RST_PXWRI_M, OP_RST_PXPASTE_M : begin
        emit_cfg     = 1'b1;
        cfg_cmd.func = opcode[0] ? DF_RST_PXWRI_M : DF_RST_PXPASTE_M;
        cfg_cmd.y    = {arg8, arg8[7:4]};              // mask color spread over y/x
        cfg_cmd.x    = {arg8[3:0], arg8};
      end
      8'b000????? : emit_rect = (opcode[2:0] == SHAPE_RECT); // other shapes dropped
      default     : ;                                  // coords, limits, reserved
    endcase
  end

  //******************************************************************
  // registers and request handshake
  //******************************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 4; i++) begin
        x[i] <= '0;
        y[i] <= '0;
      end
      max_x     <= '0;
      max_y     <= '0;
      req.valid <= 1'b0;
    end else begin
      if (req.valid && req.ready) req.valid <= 1'b0;   // engine took it
      if (pop) begin
        casez (opcode)
          8'b10?????? : x[opcode[5:4]] <= arg12;
          8'b11?????? : y[opcode[5:4]] <= arg12;
          OP_SET_MAX0 : begin max_x <= x[0]; max_y <= y[0]; end
          OP_SET_MAX1 : begin max_x <= x[1]; max_y <= y[1]; end
          OP_SET_MAX2 : begin max_x <= x[2]; max_y <= y[2]; end
          OP_SET_MAX3 : begin max_x <= x[3]; max_y <= y[3]; end
          default     : ;
        endcase
        if (emit_cfg || emit_rect) req.valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop && (emit_cfg || emit_rect)) begin
      req.kind  <= emit_rect ? REQ_RECT : REQ_CFG;
      req.cmd   <= cfg_cmd;
      req.x0    <= x[0];                               // rectangle from pair 0 to pair 1
      req.y0    <= y[0];
      req.x1    <= x[1];
      req.y1    <= y[1];
      req.color <= arg8;
      req.fill  <= q[12];                              // f bit of 000f_?sss
    end
  end

  a_req_hold : assert property (@(posedge clk) disable iff (reset)
    req.valid && !req.ready |=> req.valid && $stable({req.kind, req.cmd, req.x0, req.y0,
                                req.x1, req.y1, req.color, req.fill, req.max_x, req.max_y}));

endmodule

// ==== verilog/geo_cmd_fifo.sv ====
//********************************************************************
// show-ahead command FIFO, circular buffer with occupancy count
// almost_full flag leaves FIFO_MARGIN free slots
//********************************************************************

`timescale 1ns/1ps

module geo_cmd_fifo import geo_pkg::*; #(
  parameter int FIFO_DEPTH  = 16, // power of two
  parameter int FIFO_MARGIN = 4
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      push,
  input  cmd_word_t data,
  input  logic      pop,
  output cmd_word_t q,
  output logic      empty,
  output logic      almost_full
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  cmd_word_t        mem [FIFO_DEPTH]; // word storage
  logic [PTR_W-1:0] wr_ptr;           // wraps on its own
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;            // one extra bit to hold DEPTH
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full        = (count == (PTR_W+1)'(FIFO_DEPTH));
  assign empty       = (count == '0);
  assign almost_full = (count >= (PTR_W+1)'(FIFO_DEPTH - FIFO_MARGIN));
  assign do_push     = push && !full;
  assign do_pop      = pop && !empty;
  assign q           = mem[rd_ptr]; // head word shown ahead of pop

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= data;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // idle or push+pop together
      endcase
    end
  end

  // writer must respect fifo_cmd_busy before the buffer fills
  a_no_overflow : assert property (@(posedge clk) disable iff (reset) !(push && full));
  a_no_underflow : assert property (@(posedge clk) disable iff (reset) !(pop && empty));

endmodule

// ==== verilog/geo_req_if.sv ====
//********************************************************************
// request channel from command decoder to rectangle engine
//********************************************************************

`timescale 1ns/1ps

interface geo_req_if import geo_pkg::*; ();

  logic      valid; // request held until ready
  logic      ready; // engine can take a request
  req_kind_t kind;
  draw_cmd_t cmd;   // REQ_CFG payload
  coord_t    x0;    // rectangle corners, REQ_RECT only
  coord_t    y0;
  coord_t    x1;
  coord_t    y1;
  color_t    color; // pen color
  logic      fill;  // filled vs outline
  coord_t    max_x; // current screen limit
  coord_t    max_y;

  modport decoder (output valid, kind, cmd, x0, y0, x1, y1, color, fill, max_x, max_y,
                   input  ready);
  modport engine  (input  valid, kind, cmd, x0, y0, x1, y1, color, fill, max_x, max_y,
                   output ready);

endinterface

// ==== verilog/geo_pkg.sv ====
//********************************************************************
// shared widths, draw function codes and command opcodes
// draw command word and decoder request kind
//********************************************************************

package geo_pkg;

  localparam int COORD_W = 12; // x and y coordinate width
  localparam int COLOR_W = 8;  // pen / mask color width
  localparam int CMD_W   = 16; // incoming command word width

  typedef logic [COORD_W-1:0] coord_t;
  typedef logic [COLOR_W-1:0] color_t;
  typedef logic [CMD_W-1:0]   cmd_word_t;

  // function codes seen by the pixel writer in draw_cmd[35:32]
  typedef enum logic [3:0] {
    DF_NOP           = 4'd0,
    DF_PXWRI         = 4'd1,  // write pixel in pen color
    DF_RST_PXWRI_M   = 4'd10, // reset write collision counter
    DF_RST_PXPASTE_M = 4'd11, // reset paste collision counter
    DF_DSTRWDTH      = 4'd12, // destination raster width
    DF_SRCRWDTH      = 4'd13, // source raster width
    DF_DSTMADDR      = 4'd14, // destination base address
    DF_SRCMADDR      = 4'd15  // source base address
  } draw_func_t;

  typedef struct packed {
    draw_func_t func;  // [35:32]
    color_t     color; // [31:24]
    coord_t     y;     // [23:12]
    coord_t     x;     // [11:0]
  } draw_cmd_t;

  localparam logic [2:0] SHAPE_RECT = 3'd2; // only shape drawn

  // single-byte opcodes in cmd[15:8]
  localparam logic [7:0] OP_SET_MAX0      = 8'd95;
  localparam logic [7:0] OP_SET_MAX1      = 8'd94;
  localparam logic [7:0] OP_SET_MAX2      = 8'd93;
  localparam logic [7:0] OP_SET_MAX3      = 8'd92;
  localparam logic [7:0] OP_DST_WIDTH2    = 8'd115;
  localparam logic [7:0] OP_SRC_WIDTH2    = 8'd114;
  localparam logic [7:0] OP_DST_WIDTH3    = 8'd113;
  localparam logic [7:0] OP_SRC_WIDTH3    = 8'd112;
  localparam logic [7:0] OP_RST_PXWRI_M   = 8'd91;
  localparam logic [7:0] OP_RST_PXPASTE_M = 8'd90;

  typedef enum logic {
    REQ_CFG  = 1'b0, // pass cmd straight to output
    REQ_RECT = 1'b1  // walk a rectangle
  } req_kind_t;

endpackage
